/* Makefile */
# verilator build and run of the glb tile testbench

VERILATOR ?= verilator
TOP       ?= tb_glb_tile
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps
FAIL_MSG  ?= test failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(VERILATOR), run $(TOP), search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* glb_bank.sv */
// tile sram bank
`timescale 1ns/1ps
`default_nettype none

module glb_bank
    import glb_param_pkg::*;
(
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           clk_en,
    input  wire logic [BANK_SEL_ADDR_WIDTH-1:0] bank_idx,
    glb_bank_if.bank                            port
);

    // byte offset bits drop out of the word address
    localparam int WORD_OFFSET     = $clog2(BANK_STRB_WIDTH);
    localparam int WORD_ADDR_WIDTH = BANK_ADDR_WIDTH - WORD_OFFSET;
    localparam int BANK_WORDS      = 2 ** WORD_ADDR_WIDTH;

    logic [BANK_DATA_WIDTH-1:0] mem [BANK_WORDS];

    logic                       wr_hit;
    logic                       rd_hit;
    logic [WORD_ADDR_WIDTH-1:0] wr_word;
    logic [WORD_ADDR_WIDTH-1:0] rd_word;

    assign wr_hit = port.wr_packet.wr_en
                 && (port.wr_packet.wr_addr.fields.bank_sel == bank_idx);
    assign rd_hit = port.rdrq_packet.rd_en
                 && (port.rdrq_packet.rd_addr.fields.bank_sel == bank_idx);

    assign wr_word = port.wr_packet.wr_addr.fields.bank_addr[BANK_ADDR_WIDTH-1:WORD_OFFSET];
    assign rd_word = port.rdrq_packet.rd_addr.fields.bank_addr[BANK_ADDR_WIDTH-1:WORD_OFFSET];

    // byte strobed write
    always_ff @(posedge clk) begin
        if (clk_en && wr_hit) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (port.wr_packet.wr_strb[b]) begin
                    mem[wr_word][b*8 +: 8] <= port.wr_packet.wr_data[b*8 +: 8];
                end
            end
        end
    end

    // registered read, valid for one enabled cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            port.rdrs_packet <= '0;
        end else if (clk_en) begin
            port.rdrs_packet.rd_data_valid <= rd_hit;
            if (rd_hit) begin
                port.rdrs_packet.rd_data <= mem[rd_word];
            end
        end
    end

endmodule

`default_nettype wire

/* glb_bank_if.sv */
// switch to bank connection
`timescale 1ns/1ps
`default_nettype none

interface glb_bank_if
    import glb_packet_pkg::*;
();

    // requests from the switch
    wr_packet_t   wr_packet;
    rdrq_packet_t rdrq_packet;

    // registered response from the bank
    rdrs_packet_t rdrs_packet;

    modport sw (
        output wr_packet,
        output rdrq_packet,
        input  rdrs_packet
    );

    modport bank (
        input  wr_packet,
        input  rdrq_packet,
        output rdrs_packet
    );

endinterface

`default_nettype wire

/* glb_core_switch.sv */
// tile core switch
`timescale 1ns/1ps
`default_nettype none

module glb_core_switch
    import glb_param_pkg::*, glb_packet_pkg::*;
(
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           clk_en,
    input  wire logic [TILE_SEL_ADDR_WIDTH-1:0] glb_tile_id,
    input  wire dma_mode_t                      cfg_st_dma_mode,
    input  wire dma_mode_t                      cfg_ld_dma_mode,

    // write requests
    input  wire wr_packet_t                     wr_packet_pr2sw,
    input  wire wr_packet_t                     wr_packet_d2sw,
    input  wire wr_packet_t                     wr_packet_sr2sw,
    output wr_packet_t                          wr_packet_sw2sr,

    // read requests
    input  wire rdrq_packet_t                   rdrq_packet_pr2sw,
    input  wire rdrq_packet_t                   rdrq_packet_d2sw,
    input  wire rdrq_packet_t                   rdrq_packet_sr2sw,
    output rdrq_packet_t                        rdrq_packet_sw2sr,

    // read responses
    input  wire rdrs_packet_t                   rdrs_packet_sr2sw,
    output rdrs_packet_t                        rdrs_packet_sw2pr,
    output rdrs_packet_t                        rdrs_packet_sw2d,
    output rdrs_packet_t                        rdrs_packet_sw2sr,

    glb_bank_if.sw                              bank0,
    glb_bank_if.sw                              bank1
);

    logic cfg_st_dma_on;
    logic cfg_ld_dma_on;

    wr_packet_t wr_muxed;
    wr_packet_t wr_filtered;
    wr_packet_t wr_q;

    rdrq_sel_t    rd_sel_muxed;
    rdrq_packet_t rdrq_muxed;
    rdrq_packet_t rdrq_q;
    rdrq_sel_t    rd_sel_q;
    rdrq_sel_t    rd_sel_d1;
    rdrq_sel_t    rd_sel_d2;

    logic [BANK_SEL_ADDR_WIDTH-1:0] rd_bank_sel_d1;
    logic [BANK_SEL_ADDR_WIDTH-1:0] rd_bank_sel_d2;

    rdrs_packet_t rdrs_bank_q [BANKS_PER_TILE];
    rdrs_packet_t rdrs_bank_sel;

    function automatic logic tile_hit(input glb_addr_t addr);
        return addr.fields.tile_id == glb_tile_id;
    endfunction

    assign cfg_st_dma_on = (cfg_st_dma_mode != 2'b00);
    assign cfg_ld_dma_on = (cfg_ld_dma_mode != 2'b00);

    // write source priority, then drop foreign tiles
    always_comb begin
        if (wr_packet_pr2sw.wr_en) begin
            wr_muxed = wr_packet_pr2sw;
        end else if (cfg_st_dma_on) begin
            wr_muxed = wr_packet_d2sw;
        end else begin
            wr_muxed = wr_packet_sr2sw;
        end
        wr_filtered = tile_hit(wr_muxed.wr_addr) ? wr_muxed : '0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_q <= '0;
        end else if (clk_en) begin
            wr_q <= wr_filtered;
        end
    end

    // both banks see the write, each decodes its own bank_sel
    assign bank0.wr_packet = wr_q;
    assign bank1.wr_packet = wr_q;

    assign wr_packet_sw2sr = cfg_st_dma_on ? wr_packet_d2sw : wr_packet_sr2sw;

    // read source priority, each candidate must hit this tile
    always_comb begin
        if (rdrq_packet_pr2sw.rd_en && tile_hit(rdrq_packet_pr2sw.rd_addr)) begin
            rd_sel_muxed = PROC;
            rdrq_muxed   = rdrq_packet_pr2sw;
        end else if (cfg_ld_dma_on && rdrq_packet_d2sw.rd_en
                     && tile_hit(rdrq_packet_d2sw.rd_addr)) begin
            rd_sel_muxed = STRM_DMA;
            rdrq_muxed   = rdrq_packet_d2sw;
        end else if (!cfg_ld_dma_on && rdrq_packet_sr2sw.rd_en
                     && tile_hit(rdrq_packet_sr2sw.rd_addr)) begin
            rd_sel_muxed = STRM_RTR;
            rdrq_muxed   = rdrq_packet_sr2sw;
        end else begin
            rd_sel_muxed = NONE;
            rdrq_muxed   = '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdrq_q   <= '0;
            rd_sel_q <= NONE;
        end else if (clk_en) begin
            rdrq_q   <= rdrq_muxed;
            rd_sel_q <= rd_sel_muxed;
        end
    end

    assign bank0.rdrq_packet = rdrq_q;
    assign bank1.rdrq_packet = rdrq_q;

    assign rdrq_packet_sw2sr = cfg_ld_dma_on ? rdrq_packet_d2sw : rdrq_packet_sr2sw;

    // bank response stage plus selector delay to line up with it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdrs_bank_q[0] <= '0;
            rdrs_bank_q[1] <= '0;
            rd_sel_d1      <= NONE;
            rd_sel_d2      <= NONE;
            rd_bank_sel_d1 <= '0;
            rd_bank_sel_d2 <= '0;
        end else if (clk_en) begin
            rdrs_bank_q[0] <= bank0.rdrs_packet;
            rdrs_bank_q[1] <= bank1.rdrs_packet;
            rd_sel_d1      <= rd_sel_q;
            rd_sel_d2      <= rd_sel_d1;
            rd_bank_sel_d1 <= rdrq_q.rd_addr.fields.bank_sel;
            rd_bank_sel_d2 <= rd_bank_sel_d1;
        end
    end

    assign rdrs_bank_sel = rdrs_bank_q[rd_bank_sel_d2];

    // return each response to whoever asked
    always_comb begin
        rdrs_packet_sw2pr = '0;
        rdrs_packet_sw2d  = '0;
        if (rd_sel_d2 == PROC) begin
            rdrs_packet_sw2pr = rdrs_bank_sel;
        end
        if (rd_sel_d2 == STRM_DMA) begin
            rdrs_packet_sw2d = rdrs_bank_sel;
        end
        if (rd_sel_d2 == STRM_DMA || rd_sel_d2 == STRM_RTR) begin
            rdrs_packet_sw2sr = rdrs_bank_sel;
        end else if (cfg_ld_dma_on) begin
            // load dma owns the chain, upstream responses stop here
            rdrs_packet_sw2sr = '0;
        end else begin
            rdrs_packet_sw2sr = rdrs_packet_sr2sw;
        end
    end

endmodule

`default_nettype wire

/* glb_packet_pkg.sv */
// global buffer packet types
`default_nettype none

package glb_packet_pkg;

    import glb_param_pkg::*;

    // address seen as one word or as tile, bank and offset
    typedef struct packed {
        logic [TILE_SEL_ADDR_WIDTH-1:0] tile_id;
        logic [BANK_SEL_ADDR_WIDTH-1:0] bank_sel;
        logic [BANK_ADDR_WIDTH-1:0]     bank_addr;
    } glb_addr_fields_t;

    typedef union packed {
        logic [GLB_ADDR_WIDTH-1:0] flat;
        glb_addr_fields_t          fields;
    } glb_addr_t;

    typedef struct packed {
        logic                       wr_en;
        logic [BANK_STRB_WIDTH-1:0] wr_strb;
        glb_addr_t                  wr_addr;
        logic [BANK_DATA_WIDTH-1:0] wr_data;
    } wr_packet_t;

    typedef struct packed {
        logic      rd_en;
        glb_addr_t rd_addr;
    } rdrq_packet_t;

    typedef struct packed {
        logic [BANK_DATA_WIDTH-1:0] rd_data;
        logic                       rd_data_valid;
    } rdrs_packet_t;

    // which client owns a read in flight
    typedef enum logic [1:0] {
        NONE     = 2'd0,
        PROC     = 2'd1,
        STRM_DMA = 2'd2,
        STRM_RTR = 2'd3
    } rdrq_sel_t;

    // nonzero means dma on
    typedef logic [1:0] dma_mode_t;

endpackage

`default_nettype wire

/* glb_param_pkg.sv */
// global buffer tile constants
`default_nettype none

package glb_param_pkg;

    // byte address inside one bank
    localparam int BANK_ADDR_WIDTH = 12;

    // bank and tile select fields above the bank address
    localparam int BANK_SEL_ADDR_WIDTH = 1;
    localparam int TILE_SEL_ADDR_WIDTH = 4;

    localparam int GLB_ADDR_WIDTH = TILE_SEL_ADDR_WIDTH + BANK_SEL_ADDR_WIDTH
                                  + BANK_ADDR_WIDTH;

    // one data word and its byte strobes
    localparam int BANK_DATA_WIDTH = 64;
    localparam int BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;

    localparam int BANKS_PER_TILE = 2;

endpackage

`default_nettype wire

/* glb_tile.sv */
// global buffer tile top
`timescale 1ns/1ps
`default_nettype none

module glb_tile
    import glb_param_pkg::*, glb_packet_pkg::*;
(
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           clk_en,
    input  wire logic [TILE_SEL_ADDR_WIDTH-1:0] glb_tile_id,
    input  wire dma_mode_t                      cfg_st_dma_mode,
    input  wire dma_mode_t                      cfg_ld_dma_mode,

    // processor
    input  wire logic                           proc_wr_en,
    input  wire logic [BANK_STRB_WIDTH-1:0]     proc_wr_strb,
    input  wire logic [GLB_ADDR_WIDTH-1:0]      proc_wr_addr,
    input  wire logic [BANK_DATA_WIDTH-1:0]     proc_wr_data,
    input  wire logic                           proc_rd_en,
    input  wire logic [GLB_ADDR_WIDTH-1:0]      proc_rd_addr,
    output logic [BANK_DATA_WIDTH-1:0]          proc_rd_data,
    output logic                                proc_rd_data_valid,

    // dma
    input  wire logic                           dma_wr_en,
    input  wire logic [BANK_STRB_WIDTH-1:0]     dma_wr_strb,
    input  wire logic [GLB_ADDR_WIDTH-1:0]      dma_wr_addr,
    input  wire logic [BANK_DATA_WIDTH-1:0]     dma_wr_data,
    input  wire logic                           dma_rd_en,
    input  wire logic [GLB_ADDR_WIDTH-1:0]      dma_rd_addr,
    output logic [BANK_DATA_WIDTH-1:0]          dma_rd_data,
    output logic                                dma_rd_data_valid,

    // stream router from previous tile
    input  wire logic                           strm_in_wr_en,
    input  wire logic [BANK_STRB_WIDTH-1:0]     strm_in_wr_strb,
    input  wire logic [GLB_ADDR_WIDTH-1:0]      strm_in_wr_addr,
    input  wire logic [BANK_DATA_WIDTH-1:0]     strm_in_wr_data,
    input  wire logic                           strm_in_rd_en,
    input  wire logic [GLB_ADDR_WIDTH-1:0]      strm_in_rd_addr,
    input  wire logic [BANK_DATA_WIDTH-1:0]     strm_in_rd_data,
    input  wire logic                           strm_in_rd_data_valid,

    // stream router to next tile
    output logic                                strm_out_wr_en,
    output logic [BANK_STRB_WIDTH-1:0]          strm_out_wr_strb,
    output logic [GLB_ADDR_WIDTH-1:0]           strm_out_wr_addr,
    output logic [BANK_DATA_WIDTH-1:0]          strm_out_wr_data,
    output logic                                strm_out_rd_en,
    output logic [GLB_ADDR_WIDTH-1:0]           strm_out_rd_addr,
    output logic [BANK_DATA_WIDTH-1:0]          strm_out_rd_data,
    output logic                                strm_out_rd_data_valid
);

    wr_packet_t   wr_packet_pr2sw, wr_packet_d2sw, wr_packet_sr2sw, wr_packet_sw2sr;
    rdrq_packet_t rdrq_packet_pr2sw, rdrq_packet_d2sw, rdrq_packet_sr2sw, rdrq_packet_sw2sr;
    rdrs_packet_t rdrs_packet_sr2sw, rdrs_packet_sw2pr, rdrs_packet_sw2d, rdrs_packet_sw2sr;

    glb_bank_if bank_if_0 ();
    glb_bank_if bank_if_1 ();

    // flat client ports into packets
    assign wr_packet_pr2sw = '{proc_wr_en, proc_wr_strb, glb_addr_t'(proc_wr_addr),
                               proc_wr_data};
    assign wr_packet_d2sw  = '{dma_wr_en, dma_wr_strb, glb_addr_t'(dma_wr_addr), dma_wr_data};
    assign wr_packet_sr2sw = '{strm_in_wr_en, strm_in_wr_strb, glb_addr_t'(strm_in_wr_addr),
                               strm_in_wr_data};

    assign rdrq_packet_pr2sw = '{proc_rd_en, glb_addr_t'(proc_rd_addr)};
    assign rdrq_packet_d2sw  = '{dma_rd_en, glb_addr_t'(dma_rd_addr)};
    assign rdrq_packet_sr2sw = '{strm_in_rd_en, glb_addr_t'(strm_in_rd_addr)};

    assign rdrs_packet_sr2sw = '{strm_in_rd_data, strm_in_rd_data_valid};

    // packets back out to flat ports
    assign {proc_rd_data, proc_rd_data_valid} = rdrs_packet_sw2pr;
    assign {dma_rd_data, dma_rd_data_valid}   = rdrs_packet_sw2d;
    assign {strm_out_rd_data, strm_out_rd_data_valid} = rdrs_packet_sw2sr;
    assign {strm_out_wr_en, strm_out_wr_strb, strm_out_wr_addr, strm_out_wr_data} =
        wr_packet_sw2sr;
    assign {strm_out_rd_en, strm_out_rd_addr} = rdrq_packet_sw2sr;

    glb_core_switch glb_core_switch_i (
        .clk               (clk),
        .reset             (reset),
        .clk_en            (clk_en),
        .glb_tile_id       (glb_tile_id),
        .cfg_st_dma_mode   (cfg_st_dma_mode),
        .cfg_ld_dma_mode   (cfg_ld_dma_mode),
        .wr_packet_pr2sw   (wr_packet_pr2sw),
        .wr_packet_d2sw    (wr_packet_d2sw),
        .wr_packet_sr2sw   (wr_packet_sr2sw),
        .wr_packet_sw2sr   (wr_packet_sw2sr),
        .rdrq_packet_pr2sw (rdrq_packet_pr2sw),
        .rdrq_packet_d2sw  (rdrq_packet_d2sw),
        .rdrq_packet_sr2sw (rdrq_packet_sr2sw),
        .rdrq_packet_sw2sr (rdrq_packet_sw2sr),
        .rdrs_packet_sr2sw (rdrs_packet_sr2sw),
        .rdrs_packet_sw2pr (rdrs_packet_sw2pr),
        .rdrs_packet_sw2d  (rdrs_packet_sw2d),
        .rdrs_packet_sw2sr (rdrs_packet_sw2sr),
        .bank0             (bank_if_0.sw),
        .bank1             (bank_if_1.sw)
    );

    glb_bank glb_bank_0 (
        .clk      (clk),
        .reset    (reset),
        .clk_en   (clk_en),
        .bank_idx (1'b0),
        .port     (bank_if_0.bank)
    );

    glb_bank glb_bank_1 (
        .clk      (clk),
        .reset    (reset),
        .clk_en   (clk_en),
        .bank_idx (1'b1),
        .port     (bank_if_1.bank)
    );

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
glb_param_pkg.sv
glb_packet_pkg.sv
glb_bank_if.sv
glb_bank.sv
glb_core_switch.sv
glb_tile.sv
tb_glb_tile.sv

/* tb_glb_tasks.svh */
// tile testbench tasks
`ifndef TB_GLB_TASKS_SVH
`define TB_GLB_TASKS_SVH

    // drive point, just after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_requests();
        proc_wr_en    = 1'b0;
        dma_wr_en     = 1'b0;
        strm_in_wr_en = 1'b0;
        proc_rd_en    = 1'b0;
        dma_rd_en     = 1'b0;
        strm_in_rd_en = 1'b0;
    endtask

    task automatic init_inputs();
        clear_requests();
        proc_wr_strb          = '0;
        proc_wr_addr          = '0;
        proc_wr_data          = '0;
        proc_rd_addr          = '0;
        dma_wr_strb           = '0;
        dma_wr_addr           = '0;
        dma_wr_data           = '0;
        dma_rd_addr           = '0;
        strm_in_wr_strb       = '0;
        strm_in_wr_addr       = '0;
        strm_in_wr_data       = '0;
        strm_in_rd_addr       = '0;
        strm_in_rd_data       = '0;
        strm_in_rd_data_valid = 1'b0;
    endtask

    task automatic set_write(input rdrq_sel_t who,
                             input logic [GLB_ADDR_WIDTH-1:0] addr,
                             input logic [BANK_STRB_WIDTH-1:0] strb,
                             input logic [BANK_DATA_WIDTH-1:0] data);
        case (who)
            PROC: begin
                proc_wr_en   = 1'b1;
                proc_wr_strb = strb;
                proc_wr_addr = addr;
                proc_wr_data = data;
            end
            STRM_DMA: begin
                dma_wr_en   = 1'b1;
                dma_wr_strb = strb;
                dma_wr_addr = addr;
                dma_wr_data = data;
            end
            default: begin
                strm_in_wr_en   = 1'b1;
                strm_in_wr_strb = strb;
                strm_in_wr_addr = addr;
                strm_in_wr_data = data;
            end
        endcase
    endtask

    task automatic set_read(input rdrq_sel_t who, input logic [GLB_ADDR_WIDTH-1:0] addr);
        case (who)
            PROC: begin
                proc_rd_en   = 1'b1;
                proc_rd_addr = addr;
            end
            STRM_DMA: begin
                dma_rd_en   = 1'b1;
                dma_rd_addr = addr;
            end
            default: begin
                strm_in_rd_en   = 1'b1;
                strm_in_rd_addr = addr;
            end
        endcase
    endtask

    // STRM_RTR stands for the outbound stream port
    function automatic rdrs_packet_t rd_resp_of(input rdrq_sel_t who);
        case (who)
            PROC:     return {proc_rd_data, proc_rd_data_valid};
            STRM_DMA: return {dma_rd_data, dma_rd_data_valid};
            default:  return {strm_out_rd_data, strm_out_rd_data_valid};
        endcase
    endfunction

    function automatic wr_packet_t strm_out_wr();
        return {strm_out_wr_en, strm_out_wr_strb, strm_out_wr_addr, strm_out_wr_data};
    endfunction

    task automatic check_rdrs(input string name, input rdrs_packet_t exp,
                              input rdrs_packet_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_wr(input string name, input wr_packet_t exp, input wr_packet_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_rdrq(input string name, input rdrq_packet_t exp,
                              input rdrq_packet_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERROR %s latency: expected %0d, actual %0d", name, exp, act);
            value_errors++;
        end
    endtask

    // cycles counts steps since the request was driven
    task automatic wait_resp(input rdrq_sel_t who, input string name, inout int cycles,
                             output rdrs_packet_t got);
        got = rd_resp_of(who);
        while (!got.rd_data_valid && cycles < TIMEOUT_CYCLES) begin
            step();
            cycles++;
            got = rd_resp_of(who);
        end
        if (!got.rd_data_valid) begin
            $display("%s: no read response within %0d cycles", name, TIMEOUT_CYCLES);
            other_errors++;
        end
    endtask

    task automatic read_check(input rdrq_sel_t who, input logic [GLB_ADDR_WIDTH-1:0] addr,
                              input string name, input int latency);
        int           cycles;
        rdrs_packet_t got;
        rdrs_packet_t exp;
        set_read(who, addr);
        step();
        clear_requests();
        cycles = 1;
        wait_resp(who, name, cycles, got);
        exp = '{model_read(addr), 1'b1};
        check_rdrs(name, exp, got);
        check_latency(name, latency, cycles);
    endtask

    // full write, then a partial overwrite, then read back
    task automatic test_proc_rw();
        logic [63:0]                r;
        logic [GLB_ADDR_WIDTH-1:0]  addr;
        logic [BANK_DATA_WIDTH-1:0] data;
        logic [BANK_STRB_WIDTH-1:0] strb;
        for (int i = 0; i < 6; i++) begin
            r    = rand_bits(9);
            addr = make_addr(TILE_ID, i[0], r[8:0]);
            data = rand_bits(64);
            set_write(PROC, addr, '1, data);
            model_write(addr, '1, data);
            step();
            r    = rand_bits(8);
            strb = r[7:0];
            data = rand_bits(64);
            set_write(PROC, addr, strb, data);
            model_write(addr, strb, data);
            step();
            clear_requests();
            read_check(PROC, addr, "proc_rw", 3);
            written.push_back(addr);
        end
    endtask

    task automatic test_arbitration();
        logic [GLB_ADDR_WIDTH-1:0]  addr_a;
        logic [GLB_ADDR_WIDTH-1:0]  addr_b;
        logic [BANK_DATA_WIDTH-1:0] p_data;
        logic [BANK_DATA_WIDTH-1:0] d_data;
        cfg_st_dma_mode = 2'd1;
        addr_a = make_addr(TILE_ID, 1'b0, 9'd17);
        addr_b = make_addr(TILE_ID, 1'b1, 9'd42);
        p_data = rand_bits(64);
        d_data = rand_bits(64);
        set_write(PROC, addr_a, '1, p_data);
        set_write(STRM_DMA, addr_a, '1, d_data);
        model_write(addr_a, '1, p_data);
        #1;
        // store dma owns the outbound write port
        check_wr("arbitration strm_out_wr", {1'b1, {BANK_STRB_WIDTH{1'b1}}, addr_a, d_data},
                 strm_out_wr());
        step();
        clear_requests();
        read_check(PROC, addr_a, "arbitration proc wins", 3);
        d_data = rand_bits(64);
        set_write(STRM_DMA, addr_b, '1, d_data);
        model_write(addr_b, '1, d_data);
        step();
        clear_requests();
        cfg_st_dma_mode = '0;
        read_check(PROC, addr_b, "arbitration dma only", 3);
    endtask

    task automatic test_tile_filter();
        glb_addr_t                  ga;
        logic [GLB_ADDR_WIDTH-1:0]  foreign;
        logic [BANK_DATA_WIDTH-1:0] data;
        ga.flat           = written[0];
        ga.fields.tile_id = OTHER_TILE;
        foreign           = ga.flat;
        data              = rand_bits(64);
        set_write(STRM_RTR, foreign, '1, data);
        #1;
        check_wr("tile_filter strm_out_wr", {1'b1, {BANK_STRB_WIDTH{1'b1}}, foreign, data},
                 strm_out_wr());
        step();
        clear_requests();
        set_read(PROC, foreign);
        step();
        clear_requests();
        // a foreign read must never come back
        for (int c = 0; c < 6; c++) begin
            check_rdrs("tile_filter no response", '0, rd_resp_of(PROC));
            step();
        end
        read_check(PROC, written[0], "tile_filter bank unchanged", 3);
    endtask

    task automatic test_load_dma();
        int                        cycles;
        rdrs_packet_t              got;
        rdrs_packet_t              exp;
        logic [GLB_ADDR_WIDTH-1:0] addr;
        cfg_ld_dma_mode       = 2'd2;
        addr                  = written[1];
        strm_in_rd_data       = rand_bits(64);
        strm_in_rd_data_valid = 1'b1;
        set_read(STRM_DMA, addr);
        #1;
        check_rdrq("load_dma strm_out_rd request", {1'b1, addr},
                   {strm_out_rd_en, strm_out_rd_addr});
        step();
        clear_requests();
        cycles = 1;
        wait_resp(STRM_DMA, "load_dma", cycles, got);
        exp = '{model_read(addr), 1'b1};
        check_rdrs("load_dma dma_rd", exp, got);
        check_rdrs("load_dma strm_out_rd", exp, rd_resp_of(STRM_RTR));
        check_latency("load_dma", 3, cycles);
        step();
        check_rdrs("load_dma no passthrough", '0, rd_resp_of(STRM_RTR));
        strm_in_rd_data_valid = 1'b0;
        cfg_ld_dma_mode       = '0;
    endtask

    // four reads on alternating banks, one per cycle
    task automatic test_pipeline();
        int           seen;
        int           last;
        rdrs_packet_t got;
        rdrs_packet_t exp;
        seen = 0;
        last = 0;
        for (int cycle = 1; cycle <= TIMEOUT_CYCLES && seen < 4; cycle++) begin
            if (cycle <= 4) begin
                set_read(PROC, written[cycle-1]);
            end else begin
                clear_requests();
            end
            step();
            got = rd_resp_of(PROC);
            if (got.rd_data_valid) begin
                exp = '{model_read(written[seen]), 1'b1};
                check_rdrs("pipeline order", exp, got);
                if (seen > 0) begin
                    check_latency("pipeline spacing", 1, cycle - last);
                end
                last = cycle;
                seen++;
            end
        end
        clear_requests();
        if (seen < 4) begin
            $display("pipeline: only %0d of 4 read responses arrived", seen);
            other_errors++;
        end
    endtask

    task automatic test_clk_en();
        int                        cycles;
        rdrs_packet_t              got;
        rdrs_packet_t              exp;
        logic [GLB_ADDR_WIDTH-1:0] addr;
        addr = written[2];
        set_read(PROC, addr);
        step();
        clear_requests();
        clk_en = 1'b0;
        repeat (4) step();
        clk_en = 1'b1;
        cycles = 5;
        wait_resp(PROC, "clk_en", cycles, got);
        exp = '{model_read(addr), 1'b1};
        check_rdrs("clk_en data", exp, got);
        check_latency("clk_en", 7, cycles);
    endtask

`endif

/* tb_glb_tile.sv */
// global buffer tile testbench
`timescale 1ns/1ps
`default_nettype none

module tb_glb_tile
    import glb_param_pkg::*, glb_packet_pkg::*;
();

    localparam logic [TILE_SEL_ADDR_WIDTH-1:0] TILE_ID    = 4'd3;
    localparam logic [TILE_SEL_ADDR_WIDTH-1:0] OTHER_TILE = 4'd5;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int MODEL_WORDS    = 2 ** (BANK_ADDR_WIDTH - 3);

    logic                           clk;
    logic                           reset;
    logic                           clk_en;
    logic [TILE_SEL_ADDR_WIDTH-1:0] glb_tile_id;
    dma_mode_t                      cfg_st_dma_mode;
    dma_mode_t                      cfg_ld_dma_mode;

    logic                           proc_wr_en;
    logic [BANK_STRB_WIDTH-1:0]     proc_wr_strb;
    logic [GLB_ADDR_WIDTH-1:0]      proc_wr_addr;
    logic [BANK_DATA_WIDTH-1:0]     proc_wr_data;
    logic                           proc_rd_en;
    logic [GLB_ADDR_WIDTH-1:0]      proc_rd_addr;
    logic [BANK_DATA_WIDTH-1:0]     proc_rd_data;
    logic                           proc_rd_data_valid;

    logic                           dma_wr_en;
    logic [BANK_STRB_WIDTH-1:0]     dma_wr_strb;
    logic [GLB_ADDR_WIDTH-1:0]      dma_wr_addr;
    logic [BANK_DATA_WIDTH-1:0]     dma_wr_data;
    logic                           dma_rd_en;
    logic [GLB_ADDR_WIDTH-1:0]      dma_rd_addr;
    logic [BANK_DATA_WIDTH-1:0]     dma_rd_data;
    logic                           dma_rd_data_valid;

    logic                           strm_in_wr_en;
    logic [BANK_STRB_WIDTH-1:0]     strm_in_wr_strb;
    logic [GLB_ADDR_WIDTH-1:0]      strm_in_wr_addr;
    logic [BANK_DATA_WIDTH-1:0]     strm_in_wr_data;
    logic                           strm_in_rd_en;
    logic [GLB_ADDR_WIDTH-1:0]      strm_in_rd_addr;
    logic [BANK_DATA_WIDTH-1:0]     strm_in_rd_data;
    logic                           strm_in_rd_data_valid;

    logic                           strm_out_wr_en;
    logic [BANK_STRB_WIDTH-1:0]     strm_out_wr_strb;
    logic [GLB_ADDR_WIDTH-1:0]      strm_out_wr_addr;
    logic [BANK_DATA_WIDTH-1:0]     strm_out_wr_data;
    logic                           strm_out_rd_en;
    logic [GLB_ADDR_WIDTH-1:0]      strm_out_rd_addr;
    logic [BANK_DATA_WIDTH-1:0]     strm_out_rd_data;
    logic                           strm_out_rd_data_valid;

    // expected bank contents
    logic [BANK_DATA_WIDTH-1:0] model [BANKS_PER_TILE][MODEL_WORDS];
    logic [GLB_ADDR_WIDTH-1:0]  written [$];

    int value_errors = 0;
    int other_errors = 0;

    logic [15:0] lfsr_state = 16'd5051;

    glb_tile glb_tile_i (.*);

    always #20 clk = ~clk;

    // fibonacci lfsr x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [GLB_ADDR_WIDTH-1:0] make_addr(
        input logic [TILE_SEL_ADDR_WIDTH-1:0] tile,
        input logic                           bank,
        input logic [8:0]                     word
    );
        glb_addr_t a;
        a.fields.tile_id   = tile;
        a.fields.bank_sel  = bank;
        a.fields.bank_addr = {word, 3'b000};
        return a.flat;
    endfunction

    // byte strobed update of the expected contents
    task automatic model_write(input logic [GLB_ADDR_WIDTH-1:0] addr,
                               input logic [BANK_STRB_WIDTH-1:0] strb,
                               input logic [BANK_DATA_WIDTH-1:0] data);
        glb_addr_t a;
        a.flat = addr;
        for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
            if (strb[b]) begin
                model[a.fields.bank_sel][a.fields.bank_addr[11:3]][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    function automatic logic [BANK_DATA_WIDTH-1:0] model_read(
        input logic [GLB_ADDR_WIDTH-1:0] addr
    );
        glb_addr_t a;
        a.flat = addr;
        return model[a.fields.bank_sel][a.fields.bank_addr[11:3]];
    endfunction

    `include "tb_glb_tasks.svh"

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        clk_en          = 1'b1;
        glb_tile_id     = TILE_ID;
        cfg_st_dma_mode = '0;
        cfg_ld_dma_mode = '0;
        init_inputs();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        step();
        test_proc_rw();
        test_arbitration();
        test_tile_filter();
        test_load_dma();
        test_pipeline();
        test_clk_en();
        step();
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
